// ==== design/lsu_pkg.sv ====
//////////////////////////////////////////////////
// load/store unit shared definitions
// sizes, tag and opcode types, and the structs
// passed between buffer, control and memory
//////////////////////////////////////////////////
`default_nettype none

package lsu_pkg;

    localparam int xlen         = 32;
    localparam int reg_idx_bits = 5;
    // tag 0 means no producer or an idle bus
    localparam int rob_tag_bits = 5;
    localparam int buf_idx_bits = 3;
    localparam int buf_depth    = 1 << buf_idx_bits;
    localparam int mem_words    = 256;
    localparam int mem_idx_bits = $clog2(mem_words);
    localparam int cdb_ports    = 4;

    typedef logic [rob_tag_bits-1:0] rob_tag_t;
    typedef logic [buf_idx_bits-1:0] buf_idx_t;

    typedef enum logic [2:0] {
        op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw
    } lsu_op_e;

    // one operation as it comes from dispatch
    typedef struct packed {
        rob_tag_t                rob_tag;
        logic [reg_idx_bits-1:0] rd;
        lsu_op_e                 op;
        rob_tag_t                tag1;
        rob_tag_t                tag2;
        logic [xlen-1:0]         val1;
        logic [xlen-1:0]         val2;
        logic [xlen-1:0]         imm;
    } lsu_issue_t;

    typedef struct packed {
        rob_tag_t        tag;
        logic [xlen-1:0] value;
    } cdb_t;

    // buffer slot whose addr tracks val1 + imm once the base is known
    typedef struct packed {
        lsu_issue_t      ins;
        logic [xlen-1:0] addr;
        logic            busy;
        logic            ready;
    } lsu_entry_t;

    typedef struct packed {
        logic                    valid;
        lsu_op_e                 op;
        rob_tag_t                rob_tag;
        logic [reg_idx_bits-1:0] rd;
        logic [xlen-1:0]         addr;
        logic [xlen-1:0]         wdata;
    } mem_req_t;

    typedef struct packed {
        logic                    valid;
        rob_tag_t                rob_tag;
        logic [reg_idx_bits-1:0] rd;
        logic [xlen-1:0]         data;
    } lsu_result_t;

    function automatic logic is_store(lsu_op_e op);
        return op inside {op_sb, op_sh, op_sw};
    endfunction

endpackage

`default_nettype wire

// ==== design/ls_control.sv ====
//////////////////////////////////////////////////
// ls_control
// head/tail pointers and occupancy of the
// load/store buffer, full flag, in-order issue
// decision and flush handling
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ls_control
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    input  logic       flush,
    input  rob_tag_t   rob_head,
    input  lsu_entry_t head,
    output logic       wr_en,
    output buf_idx_t   wr_idx,
    output buf_idx_t   rd_idx,
    output logic       release_head,
    output logic       clear_all,
    output logic       issue,
    output logic       full
);

    buf_idx_t              tail_q;
    buf_idx_t              head_q;
    logic [buf_idx_bits:0] count_q;
    logic [buf_idx_bits:0] count_d;
    logic                  has_space;
    logic                  store_ok;

    assign wr_idx = tail_q;
    assign rd_idx = head_q;

    // inserts beyond the last free slot are dropped
    assign has_space = count_q != (buf_idx_bits + 1)'(buf_depth);
    assign wr_en     = in_valid && has_space && !flush;

    // stores only go once they are the oldest in the ROB
    assign store_ok     = !is_store(head.ins.op) || (head.ins.rob_tag == rob_head);
    assign issue        = head.busy && head.ready && store_ok && !flush;
    assign release_head = issue;
    assign clear_all    = flush;

    assign count_d = count_q + (buf_idx_bits + 1)'(wr_en) - (buf_idx_bits + 1)'(issue);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tail_q  <= '0;
            head_q  <= '0;
            count_q <= '0;
            full    <= 1'b0;
        end else if (flush) begin
            tail_q  <= '0;
            head_q  <= '0;
            count_q <= '0;
            full    <= 1'b0;
        end else begin
            tail_q  <= tail_q + buf_idx_t'(wr_en);
            head_q  <= head_q + buf_idx_t'(issue);
            count_q <= count_d;
            full    <= count_d == (buf_idx_bits + 1)'(buf_depth);
        end
    end

endmodule

`default_nettype wire

// ==== design/ls_buffer.sv ====
//////////////////////////////////////////////////
// ls_buffer
// entry storage of the load/store queue, operand
// wakeup from the common data bus and effective
// address update when the base arrives
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module ls_buffer
    import lsu_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       wr_en,
    input  buf_idx_t   wr_idx,
    input  lsu_issue_t in_op,
    input  buf_idx_t   rd_idx,
    input  logic       release_head,
    input  logic       clear_all,
    input  cdb_t       cdb [cdb_ports],
    output lsu_entry_t head
);

    logic [buf_depth-1:0] busy_q;
    lsu_entry_t           slot_q [buf_depth];
    lsu_entry_t           fresh;

    // operand lookup on the bus where tag 0 never matches
    function automatic cdb_t resolve(
        rob_tag_t        tag,
        logic [xlen-1:0] val,
        cdb_t            bus [cdb_ports]
    );
        cdb_t r;
        r = '{tag: tag, value: val};
        // scan downward so the lowest port wins
        for (int p = cdb_ports - 1; p >= 0; p--) begin
            if (tag != '0 && bus[p].tag == tag) begin
                r = '{tag: '0, value: bus[p].value};
            end
        end
        return r;
    endfunction

    function automatic lsu_entry_t wake(lsu_entry_t e, cdb_t bus [cdb_ports]);
        cdb_t       base;
        cdb_t       data;
        lsu_entry_t n;
        base = resolve(e.ins.tag1, e.ins.val1, bus);
        data = resolve(e.ins.tag2, e.ins.val2, bus);
        n = e;
        n.ins.tag1 = base.tag;
        n.ins.val1 = base.value;
        n.ins.tag2 = data.tag;
        n.ins.val2 = data.value;
        // only meaningful once tag1 clears
        n.addr = base.value + e.ins.imm;
        return n;
    endfunction

    // incoming op also catches broadcasts of its own insert cycle
    assign fresh = wake(lsu_entry_t'{ins: in_op, addr: '0, busy: 1'b1, ready: 1'b0}, cdb);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy_q <= '0;
        end else if (clear_all) begin
            busy_q <= '0;
        end else begin
            if (release_head) begin
                busy_q[rd_idx] <= 1'b0;
            end
            if (wr_en) begin
                busy_q[wr_idx] <= 1'b1;
            end
        end
    end

    for (genvar i = 0; i < buf_depth; i++) begin : g_slot
        always_ff @(posedge clk) begin
            if (wr_en && wr_idx == buf_idx_t'(i)) begin
                slot_q[i] <= fresh;
            end else if (busy_q[i]) begin
                slot_q[i] <= wake(slot_q[i], cdb);
            end
        end
    end

    // head view with busy and ready taken from the live state
    always_comb begin
        head       = slot_q[rd_idx];
        head.busy  = busy_q[rd_idx];
        head.ready = busy_q[rd_idx]
                     && slot_q[rd_idx].ins.tag1 == '0
                     && slot_q[rd_idx].ins.tag2 == '0;
    end

endmodule

`default_nettype wire

// ==== design/mem_access.sv ====
//////////////////////////////////////////////////
// mem_access
// small data memory behind the load/store queue
// byte-lane stores, extended loads and the
// registered load result
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_access
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        issue,
    input  lsu_entry_t  head,
    output lsu_result_t result
);

    logic [xlen-1:0]         mem [mem_words];
    mem_req_t                req;
    logic [mem_idx_bits-1:0] widx;
    logic [3:0]              lane_mask;
    logic [xlen-1:0]         lane_data;
    logic [xlen-1:0]         rword;
    logic [xlen-1:0]         byte_sh;
    logic [xlen-1:0]         half_sh;
    logic [xlen-1:0]         load_val;
    logic                    store_en;
    logic                    load_en;

    logic                    valid_q;
    rob_tag_t                tag_q;
    logic [reg_idx_bits-1:0] rd_q;
    logic [xlen-1:0]         data_q;

    assign req = '{valid: issue, op: head.ins.op, rob_tag: head.ins.rob_tag,
                   rd: head.ins.rd, addr: head.addr, wdata: head.ins.val2};

    // sub-word accesses align down inside the word
    assign widx     = req.addr[mem_idx_bits+1:2];
    assign store_en = req.valid && is_store(req.op);
    assign load_en  = req.valid && !is_store(req.op);

    always_comb begin
        case (req.op)
            op_sb: begin
                lane_mask = 4'b0001 << req.addr[1:0];
                lane_data = {4{req.wdata[7:0]}};
            end
            op_sh: begin
                lane_mask = 4'b0011 << {req.addr[1], 1'b0};
                lane_data = {2{req.wdata[15:0]}};
            end
            default: begin
                lane_mask = 4'b1111;
                lane_data = req.wdata;
            end
        endcase
    end

    assign rword   = mem[widx];
    assign byte_sh = rword >> {req.addr[1:0], 3'b000};
    assign half_sh = rword >> {req.addr[1], 4'b0000};

    always_comb begin
        case (req.op)
            op_lb:   load_val = {{24{byte_sh[7]}}, byte_sh[7:0]};
            op_lbu:  load_val = {24'b0, byte_sh[7:0]};
            op_lh:   load_val = {{16{half_sh[15]}}, half_sh[15:0]};
            op_lhu:  load_val = {16'b0, half_sh[15:0]};
            default: load_val = rword;
        endcase
    end

    // contents start at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < mem_words; w++) begin
                mem[w] <= '0;
            end
        end else if (store_en) begin
            for (int b = 0; b < 4; b++) begin
                if (lane_mask[b]) begin
                    mem[widx][8*b +: 8] <= lane_data[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= load_en;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            tag_q  <= req.rob_tag;
            rd_q   <= req.rd;
            data_q <= load_val;
        end
    end

    assign result = '{valid: valid_q, rob_tag: tag_q, rd: rd_q, data: data_q};

endmodule

`default_nettype wire

// ==== design/lsu_top.sv ====
//////////////////////////////////////////////////
// lsu_top
// load/store unit: in-order queue with CDB
// wakeup, issue control and data memory stage
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_top
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        in_valid,
    input  lsu_issue_t  in_op,
    input  cdb_t        cdb [cdb_ports],
    input  rob_tag_t    rob_head,
    input  logic        flush,
    output logic        full,
    output lsu_result_t result
);

    logic       wr_en;
    buf_idx_t   wr_idx;
    buf_idx_t   rd_idx;
    logic       release_head;
    logic       clear_all;
    logic       issue;
    lsu_entry_t head;

    ls_control ls_control_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .in_valid     (in_valid),
        .flush        (flush),
        .rob_head     (rob_head),
        .head         (head),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .rd_idx       (rd_idx),
        .release_head (release_head),
        .clear_all    (clear_all),
        .issue        (issue),
        .full         (full)
    );

    ls_buffer ls_buffer_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .wr_en        (wr_en),
        .wr_idx       (wr_idx),
        .in_op        (in_op),
        .rd_idx       (rd_idx),
        .release_head (release_head),
        .clear_all    (clear_all),
        .cdb          (cdb),
        .head         (head)
    );

    // memory stage takes the head entry on the issue edge
    mem_access mem_access_i (
        .clk    (clk),
        .arst_n (arst_n),
        .issue  (issue),
        .head   (head),
        .result (result)
    );

endmodule

`default_nettype wire

// ==== bench/lsu_tb.sv ====
//////////////////////////////////////////////////
// lsu_tb
// testbench for the load/store unit: directed
// and random load/store traffic with CDB wakeup,
// checked against a shadow memory model
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lsu_tb
    import lsu_pkg::*;
();

    localparam int n_random    = 300;
    // up to 12 cycles per random op plus the directed part
    localparam int max_cycles  = n_random * 12 + 400;
    localparam int hold_cycles = 16;
    localparam int run_normal  = 0;
    localparam int run_hold    = 1;
    localparam int run_flush   = 2;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic        clk = 1'b0;
    logic        arst_n;
    logic        in_valid;
    lsu_issue_t  in_op;
    cdb_t        cdb [cdb_ports];
    rob_tag_t    rob_head;
    logic        flush;
    logic        full;
    lsu_result_t result;

    logic [31:0] lfsr = 32'd74487;
    logic [31:0] shadow [mem_words];
    logic [31:0] tag_val [32];
    rob_tag_t    tag_ctr = '0;
    lsu_result_t expected [$];
    lsu_issue_t  batch [$];
    rob_tag_t    waiting [$];
    int          cycles = 0;

    lsu_top lsu_top_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_op    (in_op),
        .cdb      (cdb),
        .rob_head (rob_head),
        .flush    (flush),
        .full     (full),
        .result   (result)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure(string line);
        $display("%s", line);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? (lfsr >> 1) ^ lfsr_taps : lfsr >> 1;
        end
        return v;
    endfunction

    function automatic rob_tag_t next_tag();
        tag_ctr = (tag_ctr == '1) ? rob_tag_t'(1) : tag_ctr + 1'b1;
        return tag_ctr;
    endfunction

    function automatic logic writes_memory(lsu_op_e op);
        return op == op_sb || op == op_sh || op == op_sw;
    endfunction

    function automatic lsu_op_e pick_load();
        case (rand_bits(3) % 5)
            0:       return op_lb;
            1:       return op_lh;
            2:       return op_lbu;
            3:       return op_lhu;
            default: return op_lw;
        endcase
    endfunction

    function automatic lsu_op_e pick_store();
        case (rand_bits(2) % 3)
            0:       return op_sb;
            1:       return op_sh;
            default: return op_sw;
        endcase
    endfunction

    // a few words only so loads hit earlier stores
    function automatic logic [31:0] rand_addr();
        return 32'h100 + rand_bits(5);
    endfunction

    // word index from bits 9:2 and sub-word lanes aligned down
    function automatic logic [31:0] mem_ref(lsu_op_e op, logic [31:0] addr,
                                            logic [31:0] wdata);
        logic [7:0]  idx;
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        idx  = addr[9:2];
        word = shadow[idx];
        b    = word[8*addr[1:0] +: 8];
        h    = word[16*addr[1] +: 16];
        case (op)
            op_sb:   shadow[idx][8*addr[1:0] +: 8] = wdata[7:0];
            op_sh:   shadow[idx][16*addr[1] +: 16] = wdata[15:0];
            op_sw:   shadow[idx] = wdata;
            default: ;
        endcase
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'h0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'h0, h};
            op_lw:   return word;
            default: return 32'h0;
        endcase
    endfunction

    // tag_mode 0 plain values, 1 random producers, 2 all operands from the CDB
    task automatic add_op(lsu_op_e op, logic [31:0] addr, logic [31:0] data, int tag_mode);
        lsu_issue_t e;
        logic [5:0] r;
        r         = 6'(rand_bits(6));
        e.imm     = {{26{r[5]}}, r};
        e.rob_tag = next_tag();
        e.rd      = 5'(rand_bits(5));
        e.op      = op;
        e.tag1    = '0;
        e.val1    = addr - e.imm;
        e.tag2    = '0;
        e.val2    = data;
        if (tag_mode == 2 || (tag_mode == 1 && rand_bits(1) != 0)) begin
            e.tag1          = next_tag();
            tag_val[e.tag1] = e.val1;
            e.val1          = rand_bits(32);
        end
        if (tag_mode == 2 || (tag_mode == 1 && rand_bits(1) != 0)) begin
            e.tag2          = next_tag();
            tag_val[e.tag2] = e.val2;
            e.val2          = rand_bits(32);
        end
        batch.push_back(e);
    endtask

    task automatic idle_cdb();
        for (int p = 0; p < cdb_ports; p++) begin
            cdb[p] = '0;
        end
    endtask

    // each port may carry one randomly picked waiting tag
    task automatic drive_cdb();
        int k;
        for (int p = 0; p < cdb_ports; p++) begin
            cdb[p] = '0;
            if (waiting.size() != 0 && rand_bits(1) != 0) begin
                k            = int'(rand_bits(3)) % waiting.size();
                cdb[p].tag   = waiting[k];
                cdb[p].value = tag_val[waiting[k]];
                waiting.delete(k);
            end
        end
    endtask

    // a store, if any, is the first op of a batch
    task automatic run_batch(int mode);
        int          sent;
        logic        released;
        logic        need_release;
        rob_tag_t    store_tag;
        rob_tag_t    other;
        lsu_issue_t  op;
        logic [31:0] base;
        logic [31:0] wdata;
        lsu_result_t r;
        sent         = 0;
        released     = 1'b0;
        store_tag    = writes_memory(batch[0].op) ? batch[0].rob_tag : '0;
        need_release = mode == run_normal && store_tag != '0;
        while (sent < batch.size() || waiting.size() != 0 || (need_release && !released)) begin
            @(negedge clk);
            in_valid = 1'b0;
            if (mode != run_normal) begin
                assert (!result.valid) else begin
                    stop_with_failure($sformatf("Error at %0t: load result behind a blocked store",
                                                $time));
                end
            end
            if (sent < batch.size() && !full) begin
                op       = batch[sent];
                in_valid = 1'b1;
                in_op    = op;
                if (op.tag1 != '0) begin
                    waiting.push_back(op.tag1);
                end
                if (op.tag2 != '0) begin
                    waiting.push_back(op.tag2);
                end
                if (mode != run_flush) begin
                    base  = (op.tag1 != '0) ? tag_val[op.tag1] : op.val1;
                    wdata = (op.tag2 != '0) ? tag_val[op.tag2] : op.val2;
                    r     = '{valid: 1'b1, rob_tag: op.rob_tag, rd: op.rd,
                              data: mem_ref(op.op, base + op.imm, wdata)};
                    if (!writes_memory(op.op)) begin
                        expected.push_back(r);
                    end
                end
                sent++;
            end
            drive_cdb();
            if (need_release && sent > 0 && rand_bits(2) == 0) begin
                released = 1'b1;
            end
            other = rob_tag_t'(rand_bits(5));
            if (other == store_tag) begin
                other = other ^ 5'd1;
            end
            rob_head = released ? store_tag : other;
        end
        @(negedge clk);
        in_valid = 1'b0;
        idle_cdb();
        if (mode != run_normal) begin
            repeat (hold_cycles) begin
                @(negedge clk);
                assert (!result.valid) else begin
                    stop_with_failure($sformatf("Error at %0t: load result behind a blocked store",
                                                $time));
                end
            end
            assert (batch.size() != buf_depth || full) else begin
                stop_with_failure($sformatf("Error at %0t: full low with a full queue", $time));
            end
            if (mode == run_flush) begin
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
                assert (!full) else begin
                    stop_with_failure($sformatf("Error at %0t: full high after flush", $time));
                end
            end else begin
                rob_head = store_tag;
            end
        end
        while (expected.size() != 0) begin
            @(negedge clk);
        end
        assert (!full) else begin
            stop_with_failure($sformatf("Error at %0t: full high with an empty queue", $time));
        end
        batch.delete();
    endtask

    // every load result is compared with the oldest expected one
    always @(negedge clk) begin
        lsu_result_t exp;
        if (result.valid) begin
            if (expected.size() == 0) begin
                stop_with_failure($sformatf("unexpected load result for tag %0d at %0t ns",
                                            result.rob_tag, $time));
            end else begin
                exp = expected.pop_front();
                assert (result.rob_tag == exp.rob_tag && result.rd == exp.rd
                        && result.data == exp.data) else begin
                    stop_with_failure($sformatf(
                        "Error at %0t: got tag %0d rd %0d data %h, expected tag %0d rd %0d data %h",
                        $time, result.rob_tag, result.rd, result.data,
                        exp.rob_tag, exp.rd, exp.data));
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            stop_with_failure($sformatf("timeout, test did not finish within %0d cycles",
                                        max_cycles));
        end
    end

    initial begin
        int          ops_done;
        logic [31:0] a;
        lsu_op_e     st;
        arst_n   = 1'b0;
        in_valid = 1'b0;
        in_op    = '0;
        rob_head = '0;
        flush    = 1'b0;
        idle_cdb();
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // every store width, then every load flavour on the same word
        for (int w = 0; w < 3; w++) begin
            st = (w == 0) ? op_sb : (w == 1) ? op_sh : op_sw;
            for (int off = 0; off < 4; off++) begin
                a = 32'h80 + off;
                add_op(st, a, rand_bits(32), 0);
                add_op(op_lb, a, 32'h0, 0);
                add_op(op_lbu, a, 32'h0, 0);
                add_op(op_lh, a, 32'h0, 0);
                add_op(op_lhu, a, 32'h0, 0);
                add_op(op_lw, a, 32'h0, 0);
                run_batch(run_normal);
            end
        end

        // all operands arrive over the CDB
        repeat (6) begin
            a = rand_addr();
            add_op(pick_store(), a, rand_bits(32), 2);
            add_op(pick_load(), a, rand_bits(32), 2);
            add_op(pick_load(), a, rand_bits(32), 2);
            add_op(pick_load(), rand_addr(), rand_bits(32), 2);
            run_batch(run_normal);
        end

        // store not at the ROB head, then a queue filled behind it
        a = rand_addr();
        add_op(op_sw, a, rand_bits(32), 1);
        add_op(op_lb, a, 32'h0, 1);
        add_op(op_lhu, a, 32'h0, 1);
        add_op(op_lw, a, 32'h0, 1);
        run_batch(run_hold);
        add_op(op_sh, a, rand_bits(32), 1);
        repeat (buf_depth - 1) add_op(pick_load(), a, 32'h0, 1);
        run_batch(run_hold);

        // flushed store must leave memory alone
        a = rand_addr();
        add_op(op_sw, a, rand_bits(32), 0);
        add_op(op_lw, a, 32'h0, 0);
        run_batch(run_normal);
        add_op(op_sw, a, rand_bits(32), 1);
        repeat (buf_depth - 1) add_op(pick_load(), a, 32'h0, 1);
        run_batch(run_flush);
        add_op(op_lw, a, 32'h0, 0);
        add_op(op_lbu, a, 32'h0, 1);
        run_batch(run_normal);

        ops_done = 0;
        while (ops_done < n_random) begin
            if (rand_bits(1) != 0) begin
                add_op(pick_store(), rand_addr(), rand_bits(32), 1);
            end
            repeat (1 + rand_bits(2) % 3) add_op(pick_load(), rand_addr(), rand_bits(32), 1);
            ops_done += batch.size();
            run_batch(run_normal);
        end

        if (expected.size() != 0) begin
            stop_with_failure("run ended with load results still outstanding");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== lsu_top.f ====
design/lsu_pkg.sv
design/ls_control.sv
design/ls_buffer.sv
design/mem_access.sv
design/lsu_top.sv
bench/lsu_tb.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - design/lsu_pkg.sv
  - design/ls_control.sv
  - design/ls_buffer.sv
  - design/mem_access.sv
  - design/lsu_top.sv
  - target: test
    files:
      - bench/lsu_tb.sv
